//--- logic/sl_pkg.sv
// SpiNNaker link bridge definitions
package sl_pkg;

////////////////////
// Packet types
////////////////////

// Packet on the host input, header bit 0 carries parity
typedef struct packed
{
	logic [7:0]  header;
	logic [31:0] key;
	logic [31:0] payload;
	logic        has_payload;
} sl_packet_t;

// Received packet with its parity status
typedef struct packed
{
	sl_packet_t pkt;
	logic       parity_err;
} sl_rx_packet_t;

////////////////////
// 2-of-7 symbols
////////////////////

// Symbol and nibble counter width
localparam int SL_CNT_W = 5;

// Nibble codes 0..15 then end-of-packet, two bits set in each
localparam logic [0:16][6:0] SL_SYM_CODES = '{
	7'h11, 7'h12, 7'h14, 7'h18, 7'h21, 7'h22, 7'h24, 7'h28,
	7'h41, 7'h42, 7'h44, 7'h48, 7'h03, 7'h0C, 7'h06, 7'h09,
	7'h60
};
localparam logic [SL_CNT_W-1:0] SL_EOP_INDEX = 5'd16;

// Data symbols per packet
localparam logic [SL_CNT_W-1:0] SL_SHORT_NIBBLES = 5'd10;
localparam logic [SL_CNT_W-1:0] SL_LONG_NIBBLES  = 5'd18;

////////////////////
// Buffering and credits
////////////////////

// Input buffer depth, a power of two, also the host's initial credits
localparam int SL_IN_DEPTH = 4;
localparam int SL_IN_PTR_W = $clog2(SL_IN_DEPTH);

// Output credits held after reset, counter wide enough for the full count
localparam int SL_OUT_CNT_W = 2;
localparam logic [SL_OUT_CNT_W-1:0] SL_OUT_CREDITS = 2'd2;

// XOR of all bits on the wire except header bit 0
function automatic logic sl_data_xor(input sl_packet_t pkt);
	logic acc;
	acc = (^pkt.header[7:1]) ^ (^pkt.key);
	if (pkt.has_payload)
		acc = acc ^ (^pkt.payload);
	return acc;
endfunction

endpackage

//--- logic/sl_credit_fifo.sv
// Credit-based input packet buffer
`timescale 1ns/1ps

module sl_credit_fifo
(
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               in_valid_i,
	input  sl_pkg::sl_packet_t in_pkt_i,
	input  logic               pop_i,
	output logic               head_valid_o,
	output sl_pkg::sl_packet_t head_pkt_o,
	output logic               in_credit_o
);

// Packet storage, one slot per host credit
sl_pkg::sl_packet_t mem [sl_pkg::SL_IN_DEPTH];

logic [sl_pkg::SL_IN_PTR_W-1:0] wr_ptr;
logic [sl_pkg::SL_IN_PTR_W-1:0] rd_ptr;
// One bit wider than the pointers so a full buffer is distinct
logic [sl_pkg::SL_IN_PTR_W:0]   count;
logic                           do_pop;

// Only a pop of a real packet frees a slot
assign do_pop       = pop_i && head_valid_o;
assign head_valid_o = (count != '0);
assign head_pkt_o   = mem[rd_ptr];

// Write side
always_ff @(posedge clk_i)
begin
	if (in_valid_i)
		mem[wr_ptr] <= in_pkt_i;
end

// Pointers, occupancy and credit return
always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		wr_ptr      <= '0;
		rd_ptr      <= '0;
		count       <= '0;
		in_credit_o <= 1'b0;
	end
	else
	begin
		// Pointers wrap naturally at the depth
		if (in_valid_i)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({in_valid_i, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
		endcase
		// One credit back per released packet
		in_credit_o <= do_pop;
	end
end

endmodule

//--- logic/sl_tx.sv
// 2-of-7 link transmitter
`timescale 1ns/1ps

module sl_tx
(
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               head_valid_i,
	input  sl_pkg::sl_packet_t head_pkt_i,
	output logic               pop_o,
	output logic [6:0]         data_2of7_o,
	input  logic               ack_i
);

// Head packet with the parity bit inserted
sl_pkg::sl_packet_t          tx_pkt;
// Remaining nibbles, next one in the low bits
logic [71:0]                 shreg;
// Symbols already sent for this packet, EOP included
logic [sl_pkg::SL_CNT_W-1:0] sym_cnt;
logic [sl_pkg::SL_CNT_W-1:0] nib_total;
logic                        busy;
// Last ack level seen
logic                        ack_q;
logic                        ack_seen;

////////////////////
// Parity insertion
////////////////////

// Bit 0 makes the whole packet odd parity
always_comb
begin
	tx_pkt           = head_pkt_i;
	tx_pkt.header[0] = ~sl_pkg::sl_data_xor(head_pkt_i);
end

// Take a packet whenever idle
assign pop_o    = head_valid_i && !busy;
// Any change of ack level releases the next symbol
assign ack_seen = busy && (ack_i != ack_q);

////////////////////
// Nibble serialiser
////////////////////

// Header low nibble goes out at pop, so the rest starts one nibble in
always_ff @(posedge clk_i)
begin
	if (pop_o)
	begin
		shreg     <= {tx_pkt.payload, tx_pkt.key, tx_pkt.header} >> 4;
		nib_total <= tx_pkt.has_payload ? sl_pkg::SL_LONG_NIBBLES
		                                : sl_pkg::SL_SHORT_NIBBLES;
	end
	else if (ack_seen)
		shreg <= shreg >> 4;
end

////////////////////
// NRZ encoder
////////////////////

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		busy        <= 1'b0;
		sym_cnt     <= '0;
		ack_q       <= 1'b0;
		data_2of7_o <= '0;
	end
	else
	begin
		ack_q <= ack_i;
		if (pop_o)
		begin
			// First symbol straight from the head packet
			busy        <= 1'b1;
			sym_cnt     <= 5'd1;
			data_2of7_o <= data_2of7_o ^ sl_pkg::SL_SYM_CODES[tx_pkt.header[3:0]];
		end
		else if (ack_seen)
		begin
			sym_cnt <= sym_cnt + 1'b1;
			if (sym_cnt < nib_total)
				data_2of7_o <= data_2of7_o ^ sl_pkg::SL_SYM_CODES[shreg[3:0]];
			else if (sym_cnt == nib_total)
				data_2of7_o <= data_2of7_o ^ sl_pkg::SL_SYM_CODES[sl_pkg::SL_EOP_INDEX];
			else
				busy <= 1'b0;  // EOP acked, packet done
		end
	end
end

endmodule

//--- logic/sl_rx.sv
// 2-of-7 link receiver
`timescale 1ns/1ps

module sl_rx
(
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [6:0]            data_2of7_i,
	output logic                  ack_o,
	output logic                  out_valid_o,
	output sl_pkg::sl_rx_packet_t out_pkt_o,
	input  logic                  out_credit_i
);

// Two-flop synchroniser
logic [6:0]                      sync_1;
logic [6:0]                      sync_2;
// Wire level after the last accepted symbol
logic [6:0]                      level_q;
logic [6:0]                      diff;
logic                            two_hot;
logic                            sym_hit;
logic [sl_pkg::SL_CNT_W-1:0]     sym_idx;
logic                            is_eop;
logic                            accept_sym;
logic                            accept_eop;
// Nibbles enter at the top, oldest ends up lowest
logic [71:0]                     shreg;
logic [71:0]                     pkt_bits;
logic [sl_pkg::SL_CNT_W-1:0]     nib_cnt;
logic [sl_pkg::SL_OUT_CNT_W-1:0] credit_cnt;
sl_pkg::sl_packet_t              rx_pkt;

////////////////////
// Symbol decode
////////////////////

assign diff    = sync_2 ^ level_q;
assign two_hot = ($countones(diff) == 2);

// Table lookup of the transition pattern
always_comb
begin
	sym_hit = 1'b0;
	sym_idx = '0;
	for (int i = 0; i <= int'(sl_pkg::SL_EOP_INDEX); i++)
	begin
		if (diff == sl_pkg::SL_SYM_CODES[i])
		begin
			sym_hit = 1'b1;
			sym_idx = sl_pkg::SL_CNT_W'(i);
		end
	end
end

assign is_eop     = sym_hit && (sym_idx == sl_pkg::SL_EOP_INDEX);
// Data and unknown symbols go at once
assign accept_sym = two_hot && !is_eop;
// EOP waits for a credit not already spent by a pending output
assign accept_eop = two_hot && is_eop && (credit_cnt != '0) && !out_valid_o;

////////////////////
// Packet assembly
////////////////////

// A short packet sits in the top 40 bits
always_comb
begin
	rx_pkt.has_payload = (nib_cnt == sl_pkg::SL_LONG_NIBBLES);
	pkt_bits           = rx_pkt.has_payload ? shreg : (shreg >> 32);
	rx_pkt.header      = pkt_bits[7:0];
	rx_pkt.key         = pkt_bits[39:8];
	rx_pkt.payload     = rx_pkt.has_payload ? pkt_bits[71:40] : '0;
end

always_ff @(posedge clk_i)
begin
	if (accept_sym && sym_hit)
		shreg <= {sym_idx[3:0], shreg[71:4]};
	if (accept_eop)
	begin
		out_pkt_o.pkt        <= rx_pkt;
		// Even parity on the wire is an error
		out_pkt_o.parity_err <= ~(sl_pkg::sl_data_xor(rx_pkt) ^ rx_pkt.header[0]);
	end
end

////////////////////
// Control and credits
////////////////////

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		sync_1      <= '0;
		sync_2      <= '0;
		level_q     <= '0;
		ack_o       <= 1'b0;
		nib_cnt     <= '0;
		out_valid_o <= 1'b0;
		credit_cnt  <= sl_pkg::SL_OUT_CREDITS;
	end
	else
	begin
		sync_1      <= data_2of7_i;
		sync_2      <= sync_1;
		out_valid_o <= accept_eop;
		// Accepting a symbol moves the reference level and toggles ack
		if (accept_sym || accept_eop)
		begin
			level_q <= sync_2;
			ack_o   <= ~ack_o;
		end
		if (accept_eop)
			nib_cnt <= '0;
		else if (accept_sym && sym_hit)
			nib_cnt <= nib_cnt + 1'b1;
		// Credit spent while the packet is on the output
		case ({out_credit_i, out_valid_o})
			2'b10: credit_cnt <= credit_cnt + 1'b1;
			2'b01: credit_cnt <= credit_cnt - 1'b1;
			default: ;
		endcase
	end
end

endmodule

//--- logic/sl_link_top.sv
// SpiNNaker link bridge top
`timescale 1ns/1ps

module sl_link_top
(
	input  logic                  clk_i,
	input  logic                  reset_i,
	// Host input, credit based
	input  logic                  in_valid_i,
	input  sl_pkg::sl_packet_t    in_pkt_i,
	output logic                  in_credit_o,
	// Host output, credit based
	output logic                  out_valid_o,
	output sl_pkg::sl_rx_packet_t out_pkt_o,
	input  logic                  out_credit_i,
	// 2-of-7 link pins
	output logic [6:0]            data_2of7_o,
	input  logic                  ack_i,
	input  logic [6:0]            data_2of7_i,
	output logic                  ack_o
);

// Buffer head toward the transmitter
logic               head_valid;
sl_pkg::sl_packet_t head_pkt;
logic               pop;

// Input buffer and credit return
sl_credit_fifo u_fifo
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.in_valid_i   (in_valid_i),
	.in_pkt_i     (in_pkt_i),
	.pop_i        (pop),
	.head_valid_o (head_valid),
	.head_pkt_o   (head_pkt),
	.in_credit_o  (in_credit_o)
);

// Outgoing link
sl_tx u_tx
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.head_valid_i (head_valid),
	.head_pkt_i   (head_pkt),
	.pop_o        (pop),
	.data_2of7_o  (data_2of7_o),
	.ack_i        (ack_i)
);

// Incoming link, drives the host output
sl_rx u_rx
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.data_2of7_i  (data_2of7_i),
	.ack_o        (ack_o),
	.out_valid_o  (out_valid_o),
	.out_pkt_o    (out_pkt_o),
	.out_credit_i (out_credit_i)
);

endmodule

//--- test/sl_link_assertions.sv
// Link symbol and credit assertions
`timescale 1ns/1ps

module sl_link_assertions
(
	input logic                            clk_i,
	input logic                            reset_i,
	input logic [6:0]                      data_2of7_i,
	input logic                            out_valid_i,
	input logic [sl_pkg::SL_OUT_CNT_W-1:0] credit_cnt_i,
	input logic                            pop_i,
	input logic                            in_credit_i
);

// Number of failed assertions so far
int fail_count = 0;

// Each NRZ symbol flips exactly two wires and idle flips none
a_two_of_seven: assert property (@(posedge clk_i) disable iff (reset_i)
	($countones(data_2of7_i ^ $past(data_2of7_i)) == 0) ||
	($countones(data_2of7_i ^ $past(data_2of7_i)) == 2))
	else
	begin
		$error("link data changed in other than 0 or 2 bits");
		fail_count++;
	end

// A packet goes out only against a held credit
a_out_credit: assert property (@(posedge clk_i) disable iff (reset_i)
	out_valid_i |-> (credit_cnt_i != '0))
	else
	begin
		$error("out_valid_o high with no output credit");
		fail_count++;
	end

// Credit pulse follows a pop by one cycle
a_in_credit: assert property (@(posedge clk_i) disable iff (reset_i)
	in_credit_i |-> $past(pop_i))
	else
	begin
		$error("in_credit_o pulsed without a buffer pop");
		fail_count++;
	end

endmodule

bind sl_link_top sl_link_assertions u_assertions
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.data_2of7_i  (data_2of7_o),
	.out_valid_i  (out_valid_o),
	.credit_cnt_i (u_rx.credit_cnt),
	.pop_i        (pop),
	.in_credit_i  (in_credit_o)
);

//--- test/sl_link_tb.sv
// SpiNNaker link bridge testbench
`timescale 1ns/1ps

module sl_link_tb;

// Packets per test
localparam int LOOP_PACKETS   = 100;
localparam int BP_PACKETS     = 100;
// 200 packets of 19 symbols at up to 12 cycles each plus room for credit stalls
localparam int TIMEOUT_CYCLES = 200 * 19 * 12 + 10000;
// Table of output credit stall lengths
localparam int STALL_SLOTS    = 256;

logic                  clk_i;
logic                  reset_i;
logic                  in_valid_i;
sl_pkg::sl_packet_t    in_pkt_i;
logic                  in_credit_o;
logic                  out_valid_o;
sl_pkg::sl_rx_packet_t out_pkt_o;
logic                  out_credit_i;
// Loopback wires between the link pins
logic [6:0]            link_data;
logic                  link_ack;

// Reference model and counters
integer                seed;
sl_pkg::sl_packet_t    expected_q [$];
sl_pkg::sl_rx_packet_t exp_rx;
int host_credits;
int sent_total;
int recv_total;
int returned_total;
int credit_pulses;
int pending_returns;
int checks;
int errors;
int test_checks;
int test_errors;
int tests_run;
int tests_failed;
int cycle_count;
int stall_idx;
int stall_len [STALL_SLOTS];
logic withhold_en;
string current_test;

sl_link_top u_sl_link_top
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.in_valid_i   (in_valid_i),
	.in_pkt_i     (in_pkt_i),
	.in_credit_o  (in_credit_o),
	.out_valid_o  (out_valid_o),
	.out_pkt_o    (out_pkt_o),
	.out_credit_i (out_credit_i),
	.data_2of7_o  (link_data),
	.ack_i        (link_ack),
	.data_2of7_i  (link_data),
	.ack_o        (link_ack)
);

initial
begin
	clk_i = 1'b0;
	forever #20 clk_i = ~clk_i;
end

////////////////////
// Model and checks
////////////////////

// Expected arrival keeps the payload only on long packets and sets bit 0 for odd parity
function automatic sl_pkg::sl_packet_t expected_of(input sl_pkg::sl_packet_t pkt);
	sl_pkg::sl_packet_t e;
	logic               p;
	e = pkt;
	if (!pkt.has_payload)
		e.payload = '0;
	p           = (^pkt.header[7:1]) ^ (^pkt.key) ^ (^e.payload);
	e.header[0] = ~p;
	return e;
endfunction

task automatic check_value(input string name, input logic [127:0] expected,
	input logic [127:0] actual);
	checks++;
	test_checks++;
	if (actual !== expected)
	begin
		$display("MISMATCH %s %s expected %0h actual %0h", current_test, name, expected,
			actual);
		errors++;
		test_errors++;
	end
endtask

task automatic start_test(input string name);
	current_test = name;
	test_checks  = 0;
	test_errors  = 0;
endtask

task automatic finish_test();
	tests_run++;
	if (test_errors != 0)
		tests_failed++;
	$display("%-14s %0d checks, %0d errors", current_test, test_checks, test_errors);
endtask

////////////////////
// Host input side
////////////////////

task automatic make_packet(output sl_pkg::sl_packet_t pkt);
	logic [31:0] r;
	r               = $random(seed);
	pkt.header      = r[7:0];
	pkt.has_payload = r[8];
	pkt.key         = $random(seed);
	pkt.payload     = $random(seed);
endtask

// Sends only while a credit is held and idles at random
task automatic send_packets(input int count);
	int                 sent_here;
	logic [31:0]        r;
	sl_pkg::sl_packet_t pkt;
	sent_here = 0;
	while (sent_here < count)
	begin
		@(posedge clk_i);
		#2;
		in_valid_i = 1'b0;
		r          = $random(seed);
		if (host_credits > 0 && r[1:0] != 2'b00)
		begin
			make_packet(pkt);
			in_pkt_i   = pkt;
			in_valid_i = 1'b1;
			host_credits--;
			sent_total++;
			sent_here++;
			expected_q.push_back(expected_of(pkt));
		end
	end
	@(posedge clk_i);
	#2;
	in_valid_i = 1'b0;
endtask

task automatic wait_drain();
	while (recv_total < sent_total)
		@(posedge clk_i);
endtask

////////////////////
// Monitor
////////////////////

// Samples at the edge and so sees the values of the cycle before
always @(posedge clk_i)
begin
	if (!reset_i)
	begin
		if (in_credit_o)
		begin
			host_credits++;
			credit_pulses++;
		end
		if (host_credits > sl_pkg::SL_IN_DEPTH)
		begin
			$display("%s: host holds %0d input credits, more than the buffer depth",
				current_test, host_credits);
			errors++;
			test_errors++;
		end
		if (out_valid_o)
		begin
			recv_total++;
			// Output never runs ahead of returned credits by more than the initial count
			if (recv_total > returned_total + int'(sl_pkg::SL_OUT_CREDITS))
			begin
				$display("%s: packet %0d sent with only %0d output credits returned",
					current_test, recv_total, returned_total);
				errors++;
				test_errors++;
			end
			if (expected_q.size() == 0)
			begin
				$display("%s: packet received with none outstanding", current_test);
				errors++;
				test_errors++;
			end
			else
			begin
				exp_rx.pkt        = expected_q.pop_front();
				exp_rx.parity_err = 1'b0;
				check_value($sformatf("packet %0d", recv_total), 128'(exp_rx),
					128'(out_pkt_o));
			end
			pending_returns++;
		end
		if (out_credit_i)
			returned_total++;
	end
end

// Host output returns one credit per packet and stalls under back-pressure
initial
begin
	forever
	begin
		@(posedge clk_i);
		#2;
		out_credit_i = 1'b0;
		if (pending_returns > 0)
		begin
			if (withhold_en && stall_len[stall_idx] != 0)
			begin
				repeat (stall_len[stall_idx]) @(posedge clk_i);
				#2;
			end
			stall_idx       = (stall_idx + 1) % STALL_SLOTS;
			out_credit_i    = 1'b1;
			pending_returns--;
		end
	end
end

initial
begin
	cycle_count = 0;
	while (cycle_count < TIMEOUT_CYCLES)
	begin
		@(posedge clk_i);
		cycle_count++;
	end
	$display("Timeout after %0d cycles, %0d of %0d packets received", cycle_count,
		recv_total, sent_total);
	$display("Testbench failed");
	$finish;
end

////////////////////
// Test sequence
////////////////////

initial
begin
	logic [31:0] r;
	seed            = 32'h8413_f79e;
	reset_i         = 1'b1;
	in_valid_i      = 1'b0;
	in_pkt_i        = '0;
	out_credit_i    = 1'b0;
	host_credits    = sl_pkg::SL_IN_DEPTH;
	sent_total      = 0;
	recv_total      = 0;
	returned_total  = 0;
	credit_pulses   = 0;
	pending_returns = 0;
	checks          = 0;
	errors          = 0;
	tests_run       = 0;
	tests_failed    = 0;
	stall_idx       = 0;
	withhold_en     = 1'b0;
	current_test    = "reset";
	// About one credit in four is held back for 1 to 256 cycles
	for (int i = 0; i < STALL_SLOTS; i++)
	begin
		r            = $random(seed);
		stall_len[i] = (r[1:0] == 2'b00) ? int'(r[9:2]) + 1 : 0;
	end
	repeat (2) @(posedge clk_i);
	#2;
	reset_i = 1'b0;

	start_test("reset_state");
	check_value("out_valid_o", '0, 128'(out_valid_o));
	check_value("in_credit_o", '0, 128'(in_credit_o));
	check_value("data_2of7_o", '0, 128'(link_data));
	check_value("ack_o", '0, 128'(link_ack));
	finish_test();

	start_test("loopback");
	send_packets(LOOP_PACKETS);
	wait_drain();
	finish_test();

	start_test("backpressure");
	withhold_en = 1'b1;
	send_packets(BP_PACKETS);
	wait_drain();
	withhold_en = 1'b0;
	finish_test();

	// Every released packet has returned its credit by now
	start_test("input_credits");
	repeat (4) @(posedge clk_i);
	check_value("credit pulses", 128'(sent_total), 128'(credit_pulses));
	check_value("host credits", 128'(sl_pkg::SL_IN_DEPTH), 128'(host_credits));
	finish_test();

	// Failures of the bound link checker count as errors
	if (u_sl_link_top.u_assertions.fail_count != 0)
	begin
		$display("%0d link assertions failed during the run",
			u_sl_link_top.u_assertions.fail_count);
		errors = errors + u_sl_link_top.u_assertions.fail_count;
	end

	$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
		tests_failed, checks, errors);
	if (errors == 0)
		$display("Testbench passed");
	else
		$display("Testbench failed");
	$finish;
end

endmodule

//--- files.f
logic/sl_pkg.sv
logic/sl_credit_fifo.sv
logic/sl_tx.sv
logic/sl_rx.sv
logic/sl_link_top.sv
test/sl_link_assertions.sv
test/sl_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the link bridge simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module sl_link_tb -o sl_link_sim \
	|| { echo "Build failed"; exit 1; }
./obj_dir/sl_link_sim > sim.log 2>&1
cat sim.log
grep -qx "Testbench passed" sim.log && echo "Run PASS" || { echo "Run FAIL"; exit 1; }
